/* audio_params.svh */
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Bits per channel sample
`define AUD_WORD_W      16

// clk cycles per bclk half period, so one bit is 4 clk
`define AUD_BCLK_HALF   2

// Sine table entries, one full period
`define AUD_SINE_LEN    48

// Frame buffer entries
`define AUD_FIFO_DEPTH  4

// Ramp nibble position inside the sample word
`define AUD_RAMP_SHIFT  10

`endif

/* audio_frame_pkg.sv */
`default_nettype none

`include "audio_params.svh"

package audio_frame_pkg;

    // One stereo frame, left word goes out first
    typedef struct packed {
        logic [`AUD_WORD_W-1:0] left;
        logic [`AUD_WORD_W-1:0] right;
    } frame_t;

    // Serializer phase, the right word maps onto lrck high
    typedef enum logic [1:0] {
        SER_IDLE  = 2'd0,  // Out of reset, before the first frame
        SER_LEFT  = 2'd1,
        SER_RIGHT = 2'd2
    } ser_state_e;

endpackage

`default_nettype wire

/* tone_pkg.sv */
`default_nettype none

package tone_pkg;

    // Waveform select
    typedef enum logic [1:0] {
        WAVE_SILENCE = 2'd0,
        WAVE_SINE    = 2'd1,
        WAVE_RAMP    = 2'd2
    } wave_op_e;

    // Tone command from the outside world
    typedef struct packed {
        wave_op_e   op;
        logic [3:0] step;  // Table increment per frame
    } tone_cmd_t;

endpackage

`default_nettype wire

/* tone_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "audio_params.svh"

module tone_gen (
    input  logic                    clk,
    input  logic                    rst_l,
    input  tone_pkg::tone_cmd_t     cmd,
    input  logic                    enable,
    input  logic                    full,
    output logic                    push,
    output audio_frame_pkg::frame_t frame
);
    import audio_frame_pkg::*;
    import tone_pkg::*;

    localparam int WORD_W = `AUD_WORD_W;
    // Index runs modulo 96, a multiple of both the sine and the ramp period
    localparam logic [6:0] IDX_WRAP = 7'(2 * `AUD_SINE_LEN);

    localparam logic [WORD_W-1:0] SINE_LUT [0:`AUD_SINE_LEN-1] = '{
        16'd0,     16'd4276,  16'd8480,  16'd12539, 16'd16383, 16'd19947,
        16'd23169, 16'd25995, 16'd28377, 16'd30272, 16'd31650, 16'd32486,
        16'd32767, 16'd32486, 16'd31650, 16'd30272, 16'd28377, 16'd25995,
        16'd23169, 16'd19947, 16'd16383, 16'd12539, 16'd8480,  16'd4276,
        16'd0,     16'd61259, 16'd57056, 16'd52997, 16'd49153, 16'd45589,
        16'd42366, 16'd39540, 16'd37159, 16'd35263, 16'd33885, 16'd33049,
        16'd32768, 16'd33049, 16'd33885, 16'd35263, 16'd37159, 16'd39540,
        16'd42366, 16'd45589, 16'd49152, 16'd52997, 16'd57056, 16'd61259
    };

    logic [6:0]        index;      // Table phase of the next frame to load
    logic [6:0]        idx_sum;
    logic [6:0]        idx_next;
    logic [6:0]        load_idx;
    logic              load;       // Refill the frame register
    logic              valid_q;    // Frame register holds a pending sample
    logic              cmd_chg;
    logic [WORD_W-1:0] left_next;
    tone_cmd_t         cmd_q;

    function automatic logic [WORD_W-1:0] left_sample(wave_op_e op, logic [6:0] idx);
        logic [5:0] sine_idx;
        logic [3:0] nib;
        sine_idx = (idx >= 7'(`AUD_SINE_LEN)) ? 6'(idx - 7'(`AUD_SINE_LEN)) : idx[5:0];
        nib      = idx[4] ? ~idx[3:0] : idx[3:0];  // Up 0..F, then back down F..0
        case (op)
            WAVE_SINE:    left_sample = SINE_LUT[sine_idx];
            WAVE_RAMP:    left_sample = WORD_W'(nib) << `AUD_RAMP_SHIFT;
            WAVE_SILENCE: left_sample = '0;
            default:      left_sample = '0;
        endcase
    endfunction

    assign cmd_chg   = (cmd != cmd_q);
    assign push      = valid_q & enable & ~full & ~cmd_chg;
    assign idx_sum   = index + {3'b000, cmd.step};
    assign idx_next  = (idx_sum >= IDX_WRAP) ? idx_sum - IDX_WRAP : idx_sum;
    assign left_next = left_sample(cmd.op, load_idx);

    // Load after each accepted push, or when nothing is pending
    always_comb begin
        load     = 1'b0;
        load_idx = index;
        if (!cmd_chg) begin
            if (push) begin
                load     = 1'b1;
                load_idx = idx_next;
            end else if (!valid_q) begin
                load = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            cmd_q   <= '0;
            index   <= '0;
            valid_q <= 1'b0;
        end else begin
            cmd_q <= cmd;
            if (cmd_chg) begin      // New command restarts the phase
                index   <= '0;
                valid_q <= 1'b0;
            end else begin
                if (push)
                    index <= idx_next;
                if (load)
                    valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            frame <= '{left: left_next, right: -left_next};
    end

endmodule

`default_nettype wire

/* frame_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "audio_params.svh"

module frame_fifo (
    input  logic                    clk,
    input  logic                    rst_l,
    input  logic                    push,
    input  logic                    pop,
    input  audio_frame_pkg::frame_t din,
    output audio_frame_pkg::frame_t dout,
    output logic                    full,
    output logic                    empty
);
    import audio_frame_pkg::*;

    localparam int PTR_W = $clog2(`AUD_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`AUD_FIFO_DEPTH + 1);

    frame_t           mem [0:`AUD_FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // Frames held
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(`AUD_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = push & ~full;   // Ignore a push into a full buffer
    assign do_pop  = pop & ~empty;
    assign full    = (count == CNT_W'(`AUD_FIFO_DEPTH));
    assign empty   = (count == '0);
    assign dout    = mem[rd_ptr];    // Head frame

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* codec_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "audio_params.svh"

module codec_serializer (
    input  logic                    clk,
    input  logic                    rst_l,
    input  audio_frame_pkg::frame_t frame,
    input  logic                    empty,
    output logic                    pop,
    output logic                    bclk,
    output logic                    lrck,
    output logic                    dacdat,
    output logic                    underrun
);
    import audio_frame_pkg::*;

    localparam int DIV_W = $clog2(`AUD_BCLK_HALF + 1);
    localparam int BITS  = $bits(frame_t);   // Left then right word

    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;    // bclk toggles on this clk
    logic             fall_tick;    // bclk falls on this clk
    logic             frame_start;
    logic [4:0]       bit_cnt;      // Bit slot within the frame
    logic [BITS-1:0]  shreg;
    ser_state_e       state;
    ser_state_e       state_next;

    assign half_tick   = (div_cnt == DIV_W'(`AUD_BCLK_HALF - 1));
    assign fall_tick   = half_tick & bclk;
    assign frame_start = fall_tick & ((state == SER_IDLE) | (bit_cnt == 5'd31));
    assign pop         = frame_start & ~empty;
    assign lrck        = (state == SER_RIGHT);
    assign dacdat      = shreg[BITS-1];     // MSB first

    //////////////////////////////////////////////////
    // Bit clock divider
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end else if (half_tick) begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Word phase FSM, lrck edges ride on falling bclk
    always_comb begin
        state_next = state;
        if (fall_tick) begin
            case (state)
                SER_IDLE: state_next = SER_LEFT;
                SER_LEFT: begin
                    if (bit_cnt == 5'd15)
                        state_next = SER_RIGHT;
                end
                SER_RIGHT: begin
                    if (bit_cnt == 5'd31)
                        state_next = SER_LEFT;
                end
                default: state_next = SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state    <= SER_IDLE;
            bit_cnt  <= '0;
            underrun <= 1'b0;
        end else begin
            state    <= state_next;
            underrun <= frame_start & empty;   // One clk per starved frame
            if (fall_tick)
                bit_cnt <= frame_start ? 5'd0 : bit_cnt + 5'd1;
        end
    end

    //////////////////////////////////////////////////
    // Shift register, loads at frame start
    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            shreg <= '0;
        end else if (fall_tick) begin
            if (frame_start)
                shreg <= empty ? '0 : frame;   // Zero frame on underrun
            else
                shreg <= shreg << 1;
        end
    end

endmodule

`default_nettype wire

/* audio_dac_top.sv */
`timescale 1ns/1ns
`default_nettype none

module audio_dac_top (
    input  logic                clk,
    input  logic                rst_l,
    input  tone_pkg::tone_cmd_t cmd,
    input  logic                enable,
    output logic                bclk,
    output logic                lrck,
    output logic                dacdat,
    output logic                underrun
);
    import audio_frame_pkg::*;

    frame_t push_frame;  // Producer to buffer
    frame_t head_frame;  // Buffer to serializer
    logic   push;
    logic   pop;
    logic   full;
    logic   empty;

    tone_gen u_tone (
        .clk    (clk),
        .rst_l  (rst_l),
        .cmd    (cmd),
        .enable (enable),
        .full   (full),
        .push   (push),
        .frame  (push_frame)
    );

    frame_fifo u_fifo (
        .clk   (clk),
        .rst_l (rst_l),
        .push  (push),
        .pop   (pop),
        .din   (push_frame),
        .dout  (head_frame),
        .full  (full),
        .empty (empty)
    );

    codec_serializer u_ser (
        .clk      (clk),
        .rst_l    (rst_l),
        .frame    (head_frame),
        .empty    (empty),
        .pop      (pop),
        .bclk     (bclk),
        .lrck     (lrck),
        .dacdat   (dacdat),
        .underrun (underrun)
    );

endmodule

`default_nettype wire

/* tb_audio_dac.sv */
`timescale 1ns/1ns
`default_nettype none

`include "audio_params.svh"

module tb_audio_dac;
    import audio_frame_pkg::*;
    import tone_pkg::*;

    localparam int FRAME_TIMEOUT = 300;   // clk cycles, one frame is 128
    localparam int DRAIN_TIMEOUT = 1500;
    localparam int ALIGN_FRAMES  = 8;

    localparam logic [15:0] SINE_REF [0:`AUD_SINE_LEN-1] = '{
        16'd0,     16'd4276,  16'd8480,  16'd12539, 16'd16383, 16'd19947,
        16'd23169, 16'd25995, 16'd28377, 16'd30272, 16'd31650, 16'd32486,
        16'd32767, 16'd32486, 16'd31650, 16'd30272, 16'd28377, 16'd25995,
        16'd23169, 16'd19947, 16'd16383, 16'd12539, 16'd8480,  16'd4276,
        16'd0,     16'd61259, 16'd57056, 16'd52997, 16'd49153, 16'd45589,
        16'd42366, 16'd39540, 16'd37159, 16'd35263, 16'd33885, 16'd33049,
        16'd32768, 16'd33049, 16'd33885, 16'd35263, 16'd37159, 16'd39540,
        16'd42366, 16'd45589, 16'd49152, 16'd52997, 16'd57056, 16'd61259
    };

    typedef struct packed {
        tone_cmd_t  cmd;
        logic       en;       // Low rows let the buffer run dry
        logic [7:0] frames;   // Frames to check
    } row_t;

    logic        clk;
    logic        rst_l;
    tone_cmd_t   cmd;
    logic        enable;
    logic        bclk;
    logic        lrck;
    logic        dacdat;
    logic        underrun;

    row_t        rows[$];
    string       names[$];
    frame_t      rx_q[$];          // Frames from the deserializer
    logic [31:0] rx_sh   = '0;
    logic [5:0]  bit_num = '0;
    logic        lr_prev = 1'b0;
    logic        lr_sync = 1'b0;   // Bit phase locked to lrck
    int          ur_total = 0;     // Underrun pulses seen so far
    int          errors   = 0;
    int unsigned seed;

    audio_dac_top dut (
        .clk      (clk),
        .rst_l    (rst_l),
        .cmd      (cmd),
        .enable   (enable),
        .bclk     (bclk),
        .lrck     (lrck),
        .dacdat   (dacdat),
        .underrun (underrun)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Deserializer, locks on the first lrck rise, then checks the lrck level per bit
    always @(posedge bclk) begin
        if (!lr_sync) begin
            if (lrck && !lr_prev) begin   // First right word
                bit_num = 6'd16;
                lr_sync = 1'b1;
            end
        end else begin
            check_val("lrck_level", {31'h0, bit_num >= 6'd16}, {31'h0, lrck});
        end
        lr_prev = lrck;
        rx_sh   = {rx_sh[30:0], dacdat};
        bit_num = bit_num + 6'd1;
        if (bit_num == 6'd32) begin
            if (lr_sync)
                rx_q.push_back(frame_t'(rx_sh));
            bit_num = 6'd0;
        end
    end

    always @(posedge clk) begin
        if (underrun)
            ur_total <= ur_total + 1;
    end

    //////////////////////////////////////////////////
    // Reference model and helpers
    function automatic int unsigned lcg_next(input int unsigned s);
        lcg_next = s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [3:0] stair_nib(input int i);
        stair_nib = (i < 16) ? 4'(i) : 4'(31 - i);   // 0..F then F..0
    endfunction

    function automatic logic [15:0] exp_left(input wave_op_e op, input int k,
                                             input logic [3:0] step);
        int idx;
        idx = k * int'(step);
        case (op)
            WAVE_SINE: exp_left = SINE_REF[idx % `AUD_SINE_LEN];
            WAVE_RAMP: exp_left = 16'(stair_nib(idx % 32)) << `AUD_RAMP_SHIFT;
            default:   exp_left = '0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s expected %h actual %h", name, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input wave_op_e op, input logic [3:0] step,
                           input logic en, input logic [7:0] frames);
        row_t row;
        row.cmd.op   = op;
        row.cmd.step = step;
        row.en       = en;
        row.frames   = frames;
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic next_frame(output frame_t f, output bit ok);
        int waited;
        waited = 0;
        f      = '0;
        ok     = 1'b0;
        while (rx_q.size() == 0 && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("Timeout: no frame came out of the serial stream in %0d cycles",
                     FRAME_TIMEOUT);
            errors++;
        end else begin
            f  = rx_q.pop_front();
            ok = 1'b1;
        end
    endtask

    // Waits for an underrun pulse and reports the frames that came out before it
    task automatic wait_underrun(output bit ok, output int frames_before);
        int waited;
        int base;
        waited = 0;
        base   = ur_total;
        rx_q.delete();
        while (ur_total == base && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok            = (ur_total != base);
        frames_before = rx_q.size();
        rx_q.delete();
        if (!ok) begin
            $display("Timeout: the buffer did not run dry within %0d cycles", DRAIN_TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_row(input string name, input row_t row);
        frame_t      got;
        frame_t      exp_f;
        bit          ok;
        int          tail;
        int          base;
        int          k;
        logic [15:0] l;
        @(negedge clk);
        if (!row.en) begin
            cmd    = row.cmd;
            enable = 1'b0;
            wait_underrun(ok, tail);
            if (!ok)
                return;
            if (tail > `AUD_FIFO_DEPTH + 1) begin   // In-flight frame plus the buffer
                $display("%s: %0d frames followed enable low, more than buffered",
                         name, tail);
                errors++;
            end
            base = ur_total - 1;
            for (k = 0; k < int'(row.frames); k++) begin
                next_frame(got, ok);
                if (!ok)
                    return;
                check_val($sformatf("%s frame %0d", name, k), 32'h0, got);
            end
            check_val({name, " underruns"}, 32'(row.frames), ur_total - base);
            return;
        end
        // Drain the previous tone, the command change restarts the index
        cmd    = '0;
        enable = 1'b0;
        wait_underrun(ok, tail);
        if (!ok)
            return;
        cmd    = row.cmd;
        enable = 1'b1;
        if (row.cmd.op == WAVE_SILENCE) begin
            for (k = 0; k < 2; k++) begin   // Skip the starved frame
                next_frame(got, ok);
                if (!ok)
                    return;
            end
            base = ur_total;
            for (k = 0; k < int'(row.frames); k++) begin
                next_frame(got, ok);
                if (!ok)
                    return;
                check_val($sformatf("%s frame %0d", name, k), 32'h0, got);
            end
            check_val({name, " underruns"}, 32'h0, ur_total - base);
            return;
        end
        got = '0;
        k   = 0;
        while (got == '0 && k < ALIGN_FRAMES) begin
            next_frame(got, ok);
            if (!ok)
                return;
            k++;
        end
        if (got == '0) begin
            $display("%s: no nonzero frame arrived after %0d frames", name, ALIGN_FRAMES);
            errors++;
            return;
        end
        base = ur_total;
        for (k = 1; k <= int'(row.frames); k++) begin
            if (k > 1) begin
                next_frame(got, ok);
                if (!ok)
                    return;
            end
            l     = exp_left(row.cmd.op, k, row.cmd.step);
            exp_f = '{left: l, right: 16'(-l)};
            check_val($sformatf("%s frame %0d", name, k), exp_f, got);
        end
        check_val({name, " underruns"}, 32'h0, ur_total - base);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    initial begin
        clk    = 1'b0;
        rst_l  = 1'b0;
        cmd    = '0;
        enable = 1'b0;
        seed   = 32'd59025;
        seed   = lcg_next(seed);

        add_row("idle_after_reset", WAVE_SILENCE, 4'd0, 1'b0, 8'd4);
        add_row("sine_step1", WAVE_SINE, 4'd1, 1'b1, 8'd60);    // Wraps past 48
        add_row("sine_step3", WAVE_SINE, 4'd3, 1'b1, 8'd20);
        add_row("sine_random", WAVE_SINE, 4'(1 + (seed >> 16) % 15), 1'b1, 8'd20);
        add_row("ramp_step1", WAVE_RAMP, 4'd1, 1'b1, 8'd40);
        add_row("silence", WAVE_SILENCE, 4'd0, 1'b1, 8'd6);
        add_row("ramp_step2", WAVE_RAMP, 4'd2, 1'b1, 8'd8);
        add_row("enable_drop", WAVE_RAMP, 4'd2, 1'b0, 8'd4);  // Same tone, enable falls

        repeat (10) @(negedge clk);
        check_val("idle_outputs", 32'h0, {28'h0, bclk, lrck, dacdat, underrun});
        rst_l = 1'b1;

        foreach (rows[r])
            run_row(names[r], rows[r]);

        check_val("lrck_sync", 32'h1, {31'h0, lr_sync});

        $display("Run complete, %0d error(s)", errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
audio_frame_pkg.sv
tone_pkg.sv
tone_gen.sv
frame_fifo.sv
codec_serializer.sv
audio_dac_top.sv
tb_audio_dac.sv

/* Makefile */
# Verilator build and run of the audio DAC testbench
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f build.f --top-module tb_audio_dac -Mdir $(OBJ_DIR) -o sim
	./$(OBJ_DIR)/sim | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
